// File: rtl/biu_pkg.sv
//////////////////////////////////////////////////
// shared types and AHB3-Lite encodings for the
// cache bus subsystem
// XLEN is fixed at 32 and a line is 4 words (16 bytes)
// only SINGLE and WRAP4 bursts are used, no locked transfers
//////////////////////////////////////////////////
package biu_pkg;

  //////////////////////////////////////////////////
  // geometry
  //////////////////////////////////////////////////
  localparam int XLEN       = 32;
  localparam int ADDR_W     = 32;                   // physical address
  localparam int LINE_WORDS = 4;
  localparam int BE_W       = XLEN / 8;             // byte enables per word
  localparam int BYTE_OFS_W = $clog2(BE_W);         // byte offset in a word
  localparam int WIDX_W     = $clog2(LINE_WORDS);   // word index in a line
  localparam int LINE_OFS_W = BYTE_OFS_W + WIDX_W;  // byte offset in a line

  //////////////////////////////////////////////////
  // AHB3-Lite encodings
  //////////////////////////////////////////////////
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  localparam logic [2:0] HSIZE_BYTE  = 3'b000;
  localparam logic [2:0] HSIZE_HWORD = 3'b001;
  localparam logic [2:0] HSIZE_WORD  = 3'b010;

  localparam logic [2:0] HBURST_SINGLE = 3'b000;
  localparam logic [2:0] HBURST_WRAP4  = 3'b010;

  // HPROT bits, OR them together
  localparam logic [3:0] HPROT_OPCODE        = 4'b0000;
  localparam logic [3:0] HPROT_DATA          = 4'b0001;
  localparam logic [3:0] HPROT_USER          = 4'b0000;
  localparam logic [3:0] HPROT_PRIVILEGED    = 4'b0010;
  localparam logic [3:0] HPROT_NON_CACHEABLE = 4'b0000;
  localparam logic [3:0] HPROT_CACHEABLE     = 4'b1000;

  localparam logic HRESP_OKAY  = 1'b0;
  localparam logic HRESP_ERROR = 1'b1;

  // RISC-V privilege levels
  localparam logic [1:0] PRV_U = 2'b00;
  localparam logic [1:0] PRV_S = 2'b01;
  localparam logic [1:0] PRV_M = 2'b11;

  //////////////////////////////////////////////////
  // request, response and beat types
  //////////////////////////////////////////////////
  typedef enum logic [1:0] {
    OP_READ_LINE,
    OP_WRITE_LINE,
    OP_READ_SINGLE,
    OP_WRITE_SINGLE
  } bus_op_e;

  typedef logic [LINE_WORDS-1:0][XLEN-1:0] line_t;  // word 0 in the low bits

  typedef struct packed {
    bus_op_e           op;
    logic [ADDR_W-1:0] addr;          // critical word for line ops
    logic [BE_W-1:0]   be;            // single ops only
    logic [1:0]        prv;
    logic              is_instr;
    logic              is_cacheable;
    line_t             wdata;         // single write uses word addr[3:2]
  } bus_req_t;

  typedef struct packed {
    line_t rdata;
    logic  err;
  } bus_rsp_t;

  typedef struct packed {
    logic              rvalid;        // read data valid, data phase
    logic              wvalid;        // write word taken, address phase
    logic              wresp;         // write data phase done
    logic [ADDR_W-1:0] adro;          // address of the current data phase
    logic [XLEN-1:0]   data;
    logic              err;
  } biu_beat_t;

endpackage

// File: rtl/line_req_issue.sv
//////////////////////////////////////////////////
// request side of the cache bus subsystem
// one request at a time, a strobe while busy is dropped
// line ops always use full byte enables and an aligned word address
//////////////////////////////////////////////////
module line_req_issue
  import biu_pkg::*;
(
  input  logic              HCLK,
  input  logic              HRESETn,
  input  logic              req_stb,
  input  bus_req_t          req,
  input  logic              biu_stb_ack,
  input  biu_beat_t         beat,
  input  logic              done,
  output logic              busy,
  output logic              biu_stb,
  output logic [ADDR_W-1:0] biu_adri,
  output logic [BE_W-1:0]   biu_be,
  output logic [2:0]        biu_type,
  output logic              biu_we,
  output logic [XLEN-1:0]   biu_di,
  output logic [1:0]        biu_prv,
  output logic              biu_is_instruction,
  output logic              biu_is_cacheable,
  output logic              desc_line
);

  typedef enum logic [1:0] {IDLE, REQ, WAIT} state_e;

  state_e            state;
  bus_req_t          req_q;   // latched request
  logic [WIDX_W-1:0] widx;    // next write word

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////
  always_ff @(posedge HCLK or negedge HRESETn)
    if (!HRESETn)
    begin
      state     <= IDLE;
      desc_line <= 1'b0;
      widx      <= '0;
    end
    else
    begin
      case (state)
        IDLE:
          if (req_stb)
          begin
            state     <= REQ;
            desc_line <= req.op inside {OP_READ_LINE, OP_WRITE_LINE};
            widx      <= req.addr[LINE_OFS_W-1:BYTE_OFS_W]; // critical word
          end
        REQ:
          if (biu_stb_ack) state <= WAIT;  // BIU took it
        WAIT:
          if (done) state <= IDLE;         // completion seen
        default: state <= IDLE;
      endcase

      if (beat.wvalid) widx <= widx + 1'b1; // wraps inside the line
    end

  // request payload
  always_ff @(posedge HCLK)
    if (state == IDLE && req_stb) req_q <= req;

  //////////////////////////////////////////////////
  // BIU request
  //////////////////////////////////////////////////
  assign busy    = (state != IDLE);
  assign biu_stb = (state == REQ);

  assign biu_adri = desc_line ? {req_q.addr[ADDR_W-1:BYTE_OFS_W], {BYTE_OFS_W{1'b0}}}
                              : req_q.addr;
  assign biu_be   = desc_line ? {BE_W{1'b1}} : req_q.be;
  assign biu_type = desc_line ? HBURST_WRAP4 : HBURST_SINGLE;
  assign biu_we   = req_q.op inside {OP_WRITE_LINE, OP_WRITE_SINGLE};
  assign biu_di   = req_q.wdata[widx];   // word for the next write ack

  assign biu_prv            = req_q.prv;
  assign biu_is_instruction = req_q.is_instr;
  assign biu_is_cacheable   = req_q.is_cacheable;

endmodule

// File: rtl/ahb_biu.sv
//////////////////////////////////////////////////
// AHB3-Lite master for the cache bus subsystem
// SINGLE and WRAP4 bursts only, HMASTLOCK tied low
// an error response aborts the rest of the burst
// biu_di must hold the word for the next write ack
//////////////////////////////////////////////////
module ahb_biu
  import biu_pkg::*;
(
  input  logic              HCLK,
  input  logic              HRESETn,

  // request side
  input  logic              biu_stb,
  output logic              biu_stb_ack,
  input  logic [ADDR_W-1:0] biu_adri,
  input  logic [BE_W-1:0]   biu_be,
  input  logic [2:0]        biu_type,      // AHB burst code
  input  logic              biu_we,
  input  logic [XLEN-1:0]   biu_di,
  input  logic [1:0]        biu_prv,
  input  logic              biu_is_instruction,
  input  logic              biu_is_cacheable,
  output biu_beat_t         beat,

  // AHB3-Lite master
  output logic              HSEL,
  output logic [ADDR_W-1:0] HADDR,
  output logic [XLEN-1:0]   HWDATA,
  output logic              HWRITE,
  output logic [2:0]        HSIZE,
  output logic [2:0]        HBURST,
  output logic [3:0]        HPROT,
  output logic [1:0]        HTRANS,
  output logic              HMASTLOCK,
  input  logic [XLEN-1:0]   HRDATA,
  input  logic              HREADY,
  input  logic              HRESP
);

  localparam logic [WIDX_W-1:0] CNT_LINE = WIDX_W'(LINE_WORDS - 1);

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////
  function automatic logic [2:0] be2hsize(input logic [BE_W-1:0] be);
    case (be)
      4'b0001, 4'b0010, 4'b0100, 4'b1000: return HSIZE_BYTE;
      4'b0011, 4'b1100:                   return HSIZE_HWORD;
      default:                            return HSIZE_WORD;
    endcase
  endfunction

  // beats left after the first one
  function automatic logic [WIDX_W-1:0] type2cnt(input logic [2:0] btype);
    return (btype == HBURST_WRAP4) ? CNT_LINE : '0;
  endfunction

  // next word, wrapping on the 16 byte line
  function automatic logic [ADDR_W-1:0] nxt_addr(input logic [ADDR_W-1:0] addr);
    logic [LINE_OFS_W-1:0] ofs;
    ofs = addr[LINE_OFS_W-1:0] + LINE_OFS_W'(BE_W);
    ofs[BYTE_OFS_W-1:0] = '0;
    return {addr[ADDR_W-1:LINE_OFS_W], ofs};
  endfunction

  function automatic logic [3:0] prot(input logic [1:0] prv,
                                      input logic       instr,
                                      input logic       cacheable);
    return (prv == PRV_U ? HPROT_USER      : HPROT_PRIVILEGED)   |
           (instr        ? HPROT_OPCODE    : HPROT_DATA)         |
           (cacheable    ? HPROT_CACHEABLE : HPROT_NON_CACHEABLE);
  endfunction

  logic [WIDX_W-1:0] burst_cnt;
  logic              aphase_act;   // address phase carries a transfer
  logic              dphase_act;   // data phase carries a transfer
  logic              dphase_we;
  logic [ADDR_W-1:0] adro_q;
  logic              biu_err;

  assign HSEL      = 1'b1;
  assign HMASTLOCK = 1'b0;

  assign biu_stb_ack = HREADY & ~|burst_cnt & biu_stb & ~biu_err;

  //////////////////////////////////////////////////
  // address phase
  //////////////////////////////////////////////////
  always_ff @(posedge HCLK or negedge HRESETn)
    if (!HRESETn)
    begin
      aphase_act <= 1'b0;
      biu_err    <= 1'b0;
      burst_cnt  <= '0;
      HADDR      <= '0;
      HWRITE     <= 1'b0;
      HSIZE      <= HSIZE_WORD;
      HBURST     <= HBURST_SINGLE;
      HPROT      <= HPROT_DATA | HPROT_PRIVILEGED | HPROT_NON_CACHEABLE;
      HTRANS     <= HTRANS_IDLE;
    end
    else
    begin
      biu_err <= 1'b0;  // single cycle flag

      if (HREADY)
      begin
        if (~|burst_cnt)
        begin
          if (biu_stb_ack)
          begin
            aphase_act <= 1'b1;
            burst_cnt  <= type2cnt(biu_type);
            HTRANS     <= HTRANS_NONSEQ;   // first beat
            HADDR      <= biu_adri;
            HWRITE     <= biu_we;
            HSIZE      <= be2hsize(biu_be);
            HBURST     <= biu_type;
            HPROT      <= prot(biu_prv, biu_is_instruction, biu_is_cacheable);
          end
          else
          begin
            aphase_act <= 1'b0;
            HTRANS     <= HTRANS_IDLE;
          end
        end
        else
        begin
          aphase_act <= 1'b1;
          burst_cnt  <= burst_cnt - 1'b1;
          HTRANS     <= HTRANS_SEQ;          // rest of the burst
          HADDR      <= nxt_addr(HADDR);
        end
      end
      else if (HRESP == HRESP_ERROR)
      begin
        // first error cycle, drop the rest of the burst
        burst_cnt  <= '0;
        aphase_act <= 1'b0;
        HTRANS     <= HTRANS_IDLE;
        biu_err    <= 1'b1;
      end
    end

  //////////////////////////////////////////////////
  // data phase
  //////////////////////////////////////////////////
  always_ff @(posedge HCLK)
    if (HREADY)
    begin
      HWDATA    <= biu_di;   // word acked in the address phase
      adro_q    <= HADDR;
      dphase_we <= HWRITE;
    end

  always_ff @(posedge HCLK or negedge HRESETn)
    if (!HRESETn)      dphase_act <= 1'b0;
    else if (HREADY)   dphase_act <= aphase_act;

  // second error cycle has HREADY high, mask the acks there
  assign beat = '{
    rvalid: HREADY & ~dphase_we & dphase_act & ~biu_err,
    wvalid: HREADY &  HWRITE    & aphase_act,
    wresp:  HREADY &  dphase_we & dphase_act & ~biu_err,
    adro:   adro_q,
    data:   HRDATA,
    err:    biu_err
  };

endmodule

// File: rtl/line_fill_collect.sv
//////////////////////////////////////////////////
// completion side of the cache bus subsystem
// read words land by address, so a wrapped burst fills in order
// rdata is only meaningful for reads without error
//////////////////////////////////////////////////
module line_fill_collect
  import biu_pkg::*;
(
  input  logic      HCLK,
  input  logic      HRESETn,
  input  biu_beat_t beat,
  input  logic      desc_line,   // 4 beats when set, else 1
  output logic      done,
  output logic      rsp_stb,
  output bus_rsp_t  rsp
);

  logic [WIDX_W-1:0] cnt;        // beats seen so far
  logic [WIDX_W-1:0] last_cnt;
  logic              ack;
  logic              err_q;
  line_t             line_q;

  // one kind per request, so read and write completions share the count
  assign ack      = beat.rvalid | beat.wresp;
  assign last_cnt = desc_line ? WIDX_W'(LINE_WORDS - 1) : '0;

  //////////////////////////////////////////////////
  // beat counter and completion
  //////////////////////////////////////////////////
  always_ff @(posedge HCLK or negedge HRESETn)
    if (!HRESETn)
    begin
      cnt     <= '0;
      rsp_stb <= 1'b0;
      err_q   <= 1'b0;
    end
    else
    begin
      rsp_stb <= 1'b0;

      if (beat.err)
      begin
        rsp_stb <= 1'b1;     // burst aborted
        err_q   <= 1'b1;
        cnt     <= '0;
      end
      else if (ack)
      begin
        if (cnt == last_cnt)
        begin
          rsp_stb <= 1'b1;   // last beat
          err_q   <= 1'b0;
          cnt     <= '0;
        end
        else
        begin
          cnt <= cnt + 1'b1;
        end
      end
    end

  // line buffer
  always_ff @(posedge HCLK)
    if (beat.rvalid) line_q[beat.adro[LINE_OFS_W-1:BYTE_OFS_W]] <= beat.data;

  assign rsp  = '{rdata: line_q, err: err_q};
  assign done = rsp_stb;   // frees the request side

endmodule

// File: rtl/cache_bus_top.sv
//////////////////////////////////////////////////
// cache bus subsystem, core side to AHB3-Lite master
// one request in flight, no back-pressure on req_stb
//////////////////////////////////////////////////
module cache_bus_top
  import biu_pkg::*;
(
  input  logic              HCLK,
  input  logic              HRESETn,

  // core side
  input  logic              req_stb,
  input  bus_req_t          req,
  output logic              busy,
  output logic              rsp_stb,
  output bus_rsp_t          rsp,

  // AHB3-Lite master
  output logic              HSEL,
  output logic [ADDR_W-1:0] HADDR,
  output logic [XLEN-1:0]   HWDATA,
  output logic              HWRITE,
  output logic [2:0]        HSIZE,
  output logic [2:0]        HBURST,
  output logic [3:0]        HPROT,
  output logic [1:0]        HTRANS,
  output logic              HMASTLOCK,
  input  logic [XLEN-1:0]   HRDATA,
  input  logic              HREADY,
  input  logic              HRESP
);

  logic              biu_stb;
  logic              biu_stb_ack;
  logic [ADDR_W-1:0] biu_adri;
  logic [BE_W-1:0]   biu_be;
  logic [2:0]        biu_type;
  logic              biu_we;
  logic [XLEN-1:0]   biu_di;
  logic [1:0]        biu_prv;
  logic              biu_is_instruction;
  logic              biu_is_cacheable;
  biu_beat_t         beat;
  logic              desc_line;
  logic              done;

  line_req_issue line_req_issue_i (
    .HCLK               (HCLK),
    .HRESETn            (HRESETn),
    .req_stb            (req_stb),
    .req                (req),
    .biu_stb_ack        (biu_stb_ack),
    .beat               (beat),
    .done               (done),
    .busy               (busy),
    .biu_stb            (biu_stb),
    .biu_adri           (biu_adri),
    .biu_be             (biu_be),
    .biu_type           (biu_type),
    .biu_we             (biu_we),
    .biu_di             (biu_di),
    .biu_prv            (biu_prv),
    .biu_is_instruction (biu_is_instruction),
    .biu_is_cacheable   (biu_is_cacheable),
    .desc_line          (desc_line)
  );

  ahb_biu ahb_biu_i (
    .HCLK               (HCLK),
    .HRESETn            (HRESETn),
    .biu_stb            (biu_stb),
    .biu_stb_ack        (biu_stb_ack),
    .biu_adri           (biu_adri),
    .biu_be             (biu_be),
    .biu_type           (biu_type),
    .biu_we             (biu_we),
    .biu_di             (biu_di),
    .biu_prv            (biu_prv),
    .biu_is_instruction (biu_is_instruction),
    .biu_is_cacheable   (biu_is_cacheable),
    .beat               (beat),
    .HSEL               (HSEL),
    .HADDR              (HADDR),
    .HWDATA             (HWDATA),
    .HWRITE             (HWRITE),
    .HSIZE              (HSIZE),
    .HBURST             (HBURST),
    .HPROT              (HPROT),
    .HTRANS             (HTRANS),
    .HMASTLOCK          (HMASTLOCK),
    .HRDATA             (HRDATA),
    .HREADY             (HREADY),
    .HRESP              (HRESP)
  );

  line_fill_collect line_fill_collect_i (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .beat      (beat),
    .desc_line (desc_line),
    .done      (done),
    .rsp_stb   (rsp_stb),
    .rsp       (rsp)
  );

endmodule

// File: testbench/tb_clk_gen.sv
//////////////////////////////////////////////////
// clock and reset for the testbench
// period 20, reset low for the first 3 rising edges
//////////////////////////////////////////////////
module tb_clk_gen
(
  output logic HCLK,
  output logic HRESETn
);

  initial
  begin
    HCLK    = 1'b0;
    HRESETn = 1'b0;
    repeat (3) @(posedge HCLK);
    #2 HRESETn = 1'b1;   // released just after the third edge
  end

  always #10 HCLK = ~HCLK;

endmodule

// File: testbench/ahb_mem_model.sv
//////////////////////////////////////////////////
// AHB3-Lite slave memory, 64 words, index HADDR[7:2]
// wait states per data phase come from wait_sel
// err_beat picks the beat of a burst that gets an
// error response or is -1 for none
//////////////////////////////////////////////////
module ahb_mem_model
  import biu_pkg::*;
(
  input  logic              HCLK,
  input  logic              HRESETn,
  input  logic [ADDR_W-1:0] HADDR,
  input  logic [XLEN-1:0]   HWDATA,
  input  logic              HWRITE,
  input  logic [2:0]        HSIZE,
  input  logic [1:0]        HTRANS,
  input  logic [1:0]        wait_sel,   // 0 to 2 wait states
  input  int                err_beat,
  output logic [XLEN-1:0]   HRDATA,
  output logic              HREADY,
  output logic              HRESP
);

  localparam int DEPTH = 64;

  logic [XLEN-1:0] mem [DEPTH];   // reference image read by the testbench
  logic            dp_act;         // data phase in progress
  logic            dp_write;
  logic [5:0]      dp_word;
  logic [2:0]      dp_size;
  logic [1:0]      dp_ofs;
  logic [3:0]      dp_mask;        // byte lanes of the data phase
  logic [1:0]      wait_left;
  logic            err1;           // first error cycle
  logic            err2;           // second error cycle
  int              dp_idx;         // beat number inside the burst
  int              next_idx;

  function automatic logic [3:0] lane_mask(input logic [2:0] size, input logic [1:0] ofs);
    case (size)
      HSIZE_BYTE:  return 4'b0001 << ofs;
      HSIZE_HWORD: return 4'b0011 << ofs;
      default:     return 4'b1111;
    endcase
  endfunction

  assign dp_mask = lane_mask(dp_size, dp_ofs);
  assign err1    = dp_act && !err2 && wait_left == 2'd0 && dp_idx == err_beat;
  assign HREADY  = !dp_act || err2 || (wait_left == 2'd0 && !err1);
  assign HRESP   = err1 || err2;
  assign HRDATA  = mem[dp_word];

  //////////////////////////////////////////////////
  // data phase sequencing
  //////////////////////////////////////////////////
  always_ff @(posedge HCLK or negedge HRESETn)
    if (!HRESETn)
    begin
      for (int i = 0; i < DEPTH; i++)
        mem[i] <= 32'h3c5a0000 ^ (i * 32'h01b35a7d);  // every address bit counts
      dp_act    <= 1'b0;
      dp_write  <= 1'b0;
      dp_word   <= '0;
      dp_size   <= HSIZE_WORD;
      dp_ofs    <= '0;
      wait_left <= '0;
      err2      <= 1'b0;
      dp_idx    <= 0;
      next_idx  <= 0;
    end
    else
    begin
      if (err1) err2 <= 1'b1;                            // two cycle error
      else if (wait_left != 2'd0) wait_left <= wait_left - 2'd1;

      if (HREADY)
      begin
        err2 <= 1'b0;
        if (dp_act && dp_write && !err2)
          for (int b = 0; b < 4; b++)
            if (dp_mask[b]) mem[dp_word][8*b +: 8] <= HWDATA[8*b +: 8];
        // next address phase
        dp_act    <= HTRANS[1];
        dp_write  <= HWRITE;
        dp_word   <= HADDR[7:2];
        dp_size   <= HSIZE;
        dp_ofs    <= HADDR[1:0];
        wait_left <= wait_sel;
        if (HTRANS == HTRANS_NONSEQ)
        begin
          dp_idx   <= 0;
          next_idx <= 1;
        end
        else if (HTRANS == HTRANS_SEQ)
        begin
          dp_idx   <= next_idx;
          next_idx <= next_idx + 1;
        end
      end
    end

endmodule

// File: testbench/tb_cache_bus.sv
//////////////////////////////////////////////////
// testbench for cache_bus_top
// random line and single requests against a shadow
// memory, random wait states and injected errors
//////////////////////////////////////////////////
module tb_cache_bus
  import biu_pkg::*;
;

  localparam int          NUM_REQ = 200;
  localparam int          LIMIT   = NUM_REQ * 40 + 20;   // cycles including reset
  localparam logic [31:0] SEED    = 32'h56c768db;

  logic              HCLK, HRESETn, req_stb, busy, rsp_stb;
  bus_req_t          req;
  bus_rsp_t          rsp;
  logic              HSEL, HWRITE, HMASTLOCK, HREADY, HRESP;
  logic [ADDR_W-1:0] HADDR;
  logic [XLEN-1:0]   HWDATA, HRDATA;
  logic [2:0]        HSIZE, HBURST;
  logic [3:0]        HPROT;
  logic [1:0]        HTRANS, wait_sel;
  int                err_beat, cycles;

  logic [31:0]       lfsr_state, wait_lfsr;
  logic [XLEN-1:0]   shadow [64];    // expected memory
  bus_req_t          cur_req;        // request under test
  int                cur_beats;
  logic              follow_read;    // read back after a single write
  int                mon_n;          // address phases seen
  logic              err_seen;
  logic              dp_valid, dp_write;
  logic [ADDR_W-1:0] dp_addr;

  tb_clk_gen clk_gen_i (.HCLK(HCLK), .HRESETn(HRESETn));

  cache_bus_top cache_bus_top_i (
    .HCLK(HCLK), .HRESETn(HRESETn), .req_stb(req_stb), .req(req), .busy(busy),
    .rsp_stb(rsp_stb), .rsp(rsp), .HSEL(HSEL), .HADDR(HADDR), .HWDATA(HWDATA),
    .HWRITE(HWRITE), .HSIZE(HSIZE), .HBURST(HBURST), .HPROT(HPROT), .HTRANS(HTRANS),
    .HMASTLOCK(HMASTLOCK), .HRDATA(HRDATA), .HREADY(HREADY), .HRESP(HRESP)
  );

  ahb_mem_model mem_model_i (
    .HCLK(HCLK), .HRESETn(HRESETn), .HADDR(HADDR), .HWDATA(HWDATA), .HWRITE(HWRITE),
    .HSIZE(HSIZE), .HTRANS(HTRANS), .wait_sel(wait_sel), .err_beat(err_beat),
    .HRDATA(HRDATA), .HREADY(HREADY), .HRESP(HRESP)
  );

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////
  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic is_line(input bus_req_t r);
    return r.op == OP_READ_LINE || r.op == OP_WRITE_LINE;
  endfunction

  // address of beat n with the 16 byte wrap for line ops
  function automatic logic [31:0] beat_addr(input bus_req_t r, input int n);
    logic [1:0] w;
    w = r.addr[3:2] + 2'(n);
    if (is_line(r)) return {r.addr[31:4], w, 2'b00};
    return r.addr;
  endfunction

  function automatic logic [2:0] size_of(input logic [3:0] be);
    if (be == 4'b0011 || be == 4'b1100) return HSIZE_HWORD;
    if (be == 4'b1111) return HSIZE_WORD;
    return HSIZE_BYTE;   // one lane only
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act)
    else stop_on_error($sformatf("FAIL %s expected %h got %h", name, exp, act));
  endtask

  task automatic check_line(input string name, input line_t exp, input line_t act);
    assert (exp === act)
    else stop_on_error($sformatf("FAIL %s expected %h got %h", name, exp, act));
  endtask

  //////////////////////////////////////////////////
  // timeout and wait states
  //////////////////////////////////////////////////
  always @(posedge HCLK)
  begin
    cycles++;
    if (cycles >= LIMIT) stop_on_error("timeout, no completion arrived in time");
    #2;
    wait_lfsr = lfsr_step(lfsr_step(wait_lfsr));
    wait_sel  = 2'(wait_lfsr[1:0] % 3);   // 0 to 2 waits
  end

  //////////////////////////////////////////////////
  // bus monitor sampled at the falling edge
  //////////////////////////////////////////////////
  always @(negedge HCLK)
  begin
    // write data must match the word of the previous address phase
    if (dp_valid && dp_write && HREADY && !HRESP)
      check_word("HWDATA", cur_req.wdata[dp_addr[3:2]], HWDATA);
    if (HRESP) err_seen = 1'b1;
    if (HREADY && HRESETn)
    begin
      dp_valid = HTRANS[1];
      dp_addr  = HADDR;
      dp_write = HWRITE;
      if (HTRANS == HTRANS_NONSEQ)
      begin
        check_word("HSEL", 32'd1, 32'(HSEL));
        check_word("HMASTLOCK", 32'd0, 32'(HMASTLOCK));
        check_word("HADDR", beat_addr(cur_req, 0), HADDR);
        check_word("HWRITE",
                   32'(cur_req.op == OP_WRITE_LINE || cur_req.op == OP_WRITE_SINGLE),
                   32'(HWRITE));
        check_word("HBURST", 32'(is_line(cur_req) ? HBURST_WRAP4 : HBURST_SINGLE),
                   32'(HBURST));
        check_word("HSIZE", 32'(is_line(cur_req) ? HSIZE_WORD : size_of(cur_req.be)),
                   32'(HSIZE));
        // bit 3 cacheable, bit 1 privileged, bit 0 data
        check_word("HPROT", {28'd0, cur_req.is_cacheable, 1'b0, cur_req.prv != PRV_U,
                   !cur_req.is_instr}, 32'(HPROT));
        mon_n    = 1;
        err_seen = 1'b0;
      end
      else if (HTRANS == HTRANS_SEQ)
      begin
        assert (!err_seen) else stop_on_error("SEQ beat issued after an error response");
        assert (mon_n < cur_beats) else stop_on_error("burst has too many beats");
        check_word("HADDR", beat_addr(cur_req, mon_n), HADDR);
        mon_n++;
      end
    end
  end

  //////////////////////////////////////////////////
  // stimulus and checks
  //////////////////////////////////////////////////
  initial
  begin
    logic [2:0] pick;
    logic [3:0] be;
    logic [1:0] ofs;
    logic [5:0] word;
    int         k;

    req_stb     = 1'b0;
    req         = '0;
    wait_sel    = '0;
    err_beat    = -1;
    cycles      = 0;
    lfsr_state  = SEED;
    wait_lfsr   = SEED;
    cur_req     = '0;
    cur_beats   = 1;
    follow_read = 1'b0;
    mon_n       = 0;
    err_seen    = 1'b0;
    dp_valid    = 1'b0;
    dp_write    = 1'b0;
    dp_addr     = '0;

    @(posedge HRESETn);
    @(posedge HCLK);
    #2;
    for (int i = 0; i < 64; i++) shadow[i] = mem_model_i.mem[i];

    for (int n = 0; n < NUM_REQ; n++)
    begin
      // build the request
      cur_req.op           = bus_op_e'(2'(take_bits(2)));
      cur_req.prv          = 2'(take_bits(2));
      if (cur_req.prv == 2'b10) cur_req.prv = PRV_S;   // reserved code
      cur_req.is_instr     = take_bits(1) != 0;
      cur_req.is_cacheable = take_bits(1) != 0;
      for (int w = 0; w < LINE_WORDS; w++) cur_req.wdata[w] = take_bits(32);
      pick = 3'(take_bits(3) % 7);
      case (pick)
        3'd0: begin be = 4'b0001; ofs = 2'd0; end
        3'd1: begin be = 4'b0010; ofs = 2'd1; end
        3'd2: begin be = 4'b0100; ofs = 2'd2; end
        3'd3: begin be = 4'b1000; ofs = 2'd3; end
        3'd4: begin be = 4'b0011; ofs = 2'd0; end
        3'd5: begin be = 4'b1100; ofs = 2'd2; end
        default: begin be = 4'b1111; ofs = 2'd0; end
      endcase
      if (follow_read)
      begin
        // full word read of the word just written
        cur_req.op   = OP_READ_SINGLE;
        cur_req.addr = {cur_req.addr[31:2], 2'b00};
        cur_req.be   = 4'b1111;
      end
      else
      begin
        cur_req.addr = {24'd0, 6'(take_bits(6)), ofs};
        cur_req.be   = be;
      end
      if (is_line(cur_req)) cur_req.addr[1:0] = 2'b00;
      follow_read = cur_req.op == OP_WRITE_SINGLE;
      cur_beats   = is_line(cur_req) ? LINE_WORDS : 1;
      k = (take_bits(3) == 0) ? int'(take_bits(2)) % cur_beats : -1;

      // issue once the DUT is free
      while (busy)
      begin
        @(posedge HCLK);
        #2;
      end
      err_beat = k;
      req      = cur_req;
      req_stb  = 1'b1;
      @(posedge HCLK);
      #2;
      req_stb = 1'b0;
      check_word("busy", 32'd1, 32'(busy));
      do @(negedge HCLK); while (!rsp_stb);

      // expected result
      check_word("rsp.err", 32'(k >= 0), 32'(rsp.err));
      word = cur_req.addr[7:2];
      case (cur_req.op)
        OP_READ_LINE:
          if (k < 0)
            check_line("rsp.rdata", {shadow[{word[5:2], 2'd3}], shadow[{word[5:2], 2'd2}],
                       shadow[{word[5:2], 2'd1}], shadow[{word[5:2], 2'd0}]}, rsp.rdata);
        OP_READ_SINGLE:
          if (k < 0) check_word("rsp.rdata", shadow[word], rsp.rdata[word[1:0]]);
        OP_WRITE_LINE:
          for (int j = 0; j < LINE_WORDS; j++)
            if (k < 0 || j < k)
              shadow[beat_addr(cur_req, j) >> 2] = cur_req.wdata[beat_addr(cur_req, j) >> 2 & 3];
        default:
          if (k < 0)
            for (int b = 0; b < 4; b++)
              if (cur_req.be[b]) shadow[word][8*b +: 8] = cur_req.wdata[word[1:0]][8*b +: 8];
      endcase
      // memory image against the shadow over the whole line
      for (int j = 0; j < LINE_WORDS; j++)
        check_word($sformatf("mem[%0d]", {word[5:2], 2'(j)}), shadow[{word[5:2], 2'(j)}],
                   mem_model_i.mem[{word[5:2], 2'(j)}]);
      if (k >= 0) follow_read = 1'b0;
    end

    $display("Test passed");
    $finish;
  end

endmodule

// File: build.f
rtl/biu_pkg.sv
rtl/line_req_issue.sv
rtl/ahb_biu.sv
rtl/line_fill_collect.sv
rtl/cache_bus_top.sv
testbench/tb_clk_gen.sv
testbench/ahb_mem_model.sv
testbench/tb_cache_bus.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the cache bus testbench with Verilator
# exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module tb_cache_bus -o sim_cache_bus
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/sim_cache_bus
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

echo "simulation finished"
exit 0
